/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := fsqrt_tb
FLIST     := flist.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST)) $(wildcard bench/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# Status follows the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

/* bench/fsqrt_tb_cases.svh */
`ifndef FSQRT_TB_CASES_SVH
`define FSQRT_TB_CASES_SVH

// Columns: operand, rm code, mode write response, flags {busy poke, stall read},
// expected value, expected invalid, expected inexact
task automatic load_cases();
  // Exact roots, even then odd exponents
  add_case(32'h40800000, 3'd0, RESP_OKAY, 2'b00, 32'h40000000, 1'b0, 1'b0);
  add_case(32'h3F800000, 3'd0, RESP_OKAY, 2'b00, 32'h3F800000, 1'b0, 1'b0);
  add_case(32'h41800000, 3'd0, RESP_OKAY, 2'b00, 32'h40800000, 1'b0, 1'b0);
  add_case(32'h41100000, 3'd0, RESP_OKAY, 2'b00, 32'h40400000, 1'b0, 1'b0);
  add_case(32'h40100000, 3'd0, RESP_OKAY, 2'b00, 32'h3FC00000, 1'b0, 1'b0);
  // 89.0, not a perfect square, 0.2 ulp above truncation
  add_case(32'h42B20000, 3'd0, RESP_OKAY, 2'b00, 32'h4116F196, 1'b0, 1'b1);
  // Root of 2.0 lies 0.2 ulp above truncation
  add_case(32'h40000000, 3'd0, RESP_OKAY, 2'b00, 32'h3FB504F3, 1'b0, 1'b1);
  add_case(32'h40000000, 3'd1, RESP_OKAY, 2'b00, 32'h3FB504F3, 1'b0, 1'b1);
  add_case(32'h40000000, 3'd2, RESP_OKAY, 2'b00, 32'h3FB504F3, 1'b0, 1'b1);
  add_case(32'h40000000, 3'd3, RESP_OKAY, 2'b00, 32'h3FB504F4, 1'b0, 1'b1);
  add_case(32'h40000000, 3'd4, RESP_OKAY, 2'b00, 32'h3FB504F3, 1'b0, 1'b1);
  // Root of 2.2 lies just past the halfway point
  add_case(32'h400CCCCD, 3'd0, RESP_OKAY, 2'b00, 32'h3FBDDACD, 1'b0, 1'b1);
  add_case(32'h400CCCCD, 3'd4, RESP_OKAY, 2'b00, 32'h3FBDDACD, 1'b0, 1'b1);
  add_case(32'h400CCCCD, 3'd3, RESP_OKAY, 2'b00, 32'h3FBDDACD, 1'b0, 1'b1);
  add_case(32'h400CCCCD, 3'd2, RESP_OKAY, 2'b00, 32'h3FBDDACC, 1'b0, 1'b1);
  add_case(32'h400CCCCD, 3'd1, RESP_OKAY, 2'b00, 32'h3FBDDACC, 1'b0, 1'b1);
  // Illegal code 5, RTZ stays in force
  add_case(32'h400CCCCD, 3'd5, RESP_SLVERR, 2'b00, 32'h3FBDDACC, 1'b0, 1'b1);
  // Special operands
  add_case(32'h00000000, 3'd0, RESP_OKAY, 2'b00, 32'h00000000, 1'b0, 1'b0);
  add_case(32'h80000000, 3'd0, RESP_OKAY, 2'b00, 32'h80000000, 1'b0, 1'b0);
  add_case(32'h7F800000, 3'd0, RESP_OKAY, 2'b00, 32'h7F800000, 1'b0, 1'b0);
  add_case(32'hC0800000, 3'd0, RESP_OKAY, 2'b00, 32'h7FC00000, 1'b1, 1'b0);
  add_case(32'h7F800001, 3'd0, RESP_OKAY, 2'b00, 32'h7FC00000, 1'b1, 1'b0);
  add_case(32'h7FC00001, 3'd0, RESP_OKAY, 2'b00, 32'h7FC00000, 1'b0, 1'b0);
  // Smallest subnormal, root is sqrt(2) times 2^-75
  add_case(32'h00000001, 3'd0, RESP_OKAY, 2'b00, 32'h1A3504F3, 1'b0, 1'b1);
  // Second start while busy, result read under back-pressure
  add_case(32'h400CCCCD, 3'd0, RESP_OKAY, 2'b11, 32'h3FBDDACD, 1'b0, 1'b1);
endtask

`endif

/* bench/fsqrt_tb.sv */
`timescale 1ns/1ps

module fsqrt_tb import fsqrt_pkg::*; ();

  // Handshake and poll limits
  localparam int BUS_TIMEOUT  = 40;
  localparam int DONE_POLLS   = 64;
  // Cycles rready stays low on a stalled read
  localparam int STALL_CYCLES = 5;

  // One table entry
  typedef struct packed {
    logic [31:0]   operand;
    logic [2:0]    rm;
    axil_resp_e    ctrl_resp;
    logic          busy_poke;
    logic          stall_read;
    fsqrt_result_t want;
  } case_t;

  logic      clk;
  logic      rst;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;

  case_t cases [$];
  int    errors;
  int    checks;
  int    tests;
  int    failed_tests;

  fsqrt_top #(
    .ADDR_W (4)
  ) fsqrt_top_inst (
    .clk      (clk),
    .rst      (rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  // 40 ns period
  always #20 clk = ~clk;

  task automatic add_case(input logic [31:0] operand, input logic [2:0] rm,
                          input axil_resp_e ctrl_resp, input logic [1:0] flags,
                          input logic [31:0] value, input logic invalid,
                          input logic inexact);
    case_t c;
    c.operand      = operand;
    c.rm           = rm;
    c.ctrl_resp    = ctrl_resp;
    // Flag bit 1 pokes the operand while busy, bit 0 stalls the result read
    c.busy_poke    = flags[1];
    c.stall_read   = flags[0];
    c.want.value   = value;
    c.want.invalid = invalid;
    c.want.inexact = inexact;
    cases.push_back(c);
  endtask

  `include "fsqrt_tb_cases.svh"

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_result(input string what, input fsqrt_result_t actual,
                              input fsqrt_result_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0d ns: %s gave %h inv %b inx %b, expected %h inv %b inx %b",
               $time, what, actual.value, actual.invalid, actual.inexact,
               expected.value, expected.invalid, expected.inexact);
    end
  endtask

  task automatic check_resp(input string what, input axil_resp_e actual,
                            input axil_resp_e expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0d ns: %s answered %s, expected %s",
               $time, what, actual.name(), expected.name());
    end
  endtask

  // Only the bits under mask are compared
  task automatic check_status(input string what, input logic [31:0] actual,
                              input logic [31:0] expected, input logic [31:0] mask);
    checks++;
    if ((actual & mask) !== (expected & mask)) begin
      errors++;
      $display("** Error at %0d ns: %s status %h, expected %h under mask %h",
               $time, what, actual, expected, mask);
    end
  endtask

  task automatic check_data(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0d ns: %s read %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Timeout ends the run at once
  task automatic abort_run(input string what);
    $display("Timed out waiting for %s at %0d ns", what, $time);
    $display("Testbench failed");
    $finish;
  endtask

  //////////////////////////////
  // AXI4-Lite manager
  //////////////////////////////

  // Entered and left 1 ns after a rising edge
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output axil_resp_e resp);
    int   cycles;
    logic aw_take;
    logic w_take;
    logic got;
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    cycles = 0;
    // Address and data may go on different edges
    while (axil_req.awvalid || axil_req.wvalid) begin
      @(negedge clk);
      aw_take = axil_req.awvalid && axil_rsp.awready;
      w_take  = axil_req.wvalid && axil_rsp.wready;
      @(posedge clk);
      #1;
      if (aw_take) axil_req.awvalid = 1'b0;
      if (w_take) axil_req.wvalid = 1'b0;
      cycles++;
      if ((axil_req.awvalid || axil_req.wvalid) && cycles > BUS_TIMEOUT) begin
        abort_run("the write address and data handshake");
      end
    end
    got    = 1'b0;
    cycles = 0;
    while (!got) begin
      @(negedge clk);
      if (axil_rsp.bvalid) begin
        resp = axil_rsp.bresp;
        got  = 1'b1;
      end
      @(posedge clk);
      #1;
      cycles++;
      if (!got && cycles > BUS_TIMEOUT) abort_run("the write response");
    end
    axil_req.bready = 1'b0;
  endtask

  // Holds rready low for stall cycles once rvalid is up
  task automatic axil_read(input logic [7:0] addr, input int stall,
                           output logic [31:0] data, output axil_resp_e resp);
    int          cycles;
    logic        taken;
    logic        got;
    logic [31:0] first;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b0;
    taken  = 1'b0;
    cycles = 0;
    while (!taken) begin
      @(negedge clk);
      taken = axil_rsp.arready;
      @(posedge clk);
      #1;
      cycles++;
      if (!taken && cycles > BUS_TIMEOUT) abort_run("the read address handshake");
    end
    axil_req.arvalid = 1'b0;
    got    = 1'b0;
    cycles = 0;
    while (!got) begin
      @(negedge clk);
      if (axil_rsp.rvalid) begin
        first = axil_rsp.rdata;
        got   = 1'b1;
      end
      @(posedge clk);
      #1;
      cycles++;
      if (!got && cycles > BUS_TIMEOUT) abort_run("the read data valid");
    end
    repeat (stall) begin
      @(posedge clk);
      #1;
    end
    axil_req.rready = 1'b1;
    @(negedge clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);
    #1;
    axil_req.rready = 1'b0;
    if (stall > 0) check_data("data held under back-pressure", data, first);
  endtask

  // Poll status until done
  task automatic wait_done();
    int          polls;
    logic [31:0] word;
    axil_resp_e  resp;
    polls = 0;
    word  = '0;
    while (!word[1]) begin
      axil_read(REG_STATUS, 0, word, resp);
      polls++;
      if (!word[1] && polls > DONE_POLLS) abort_run("the done bit in the status register");
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic run_case(input int idx);
    case_t         c;
    axil_resp_e    resp;
    logic [31:0]   word;
    logic [31:0]   status;
    fsqrt_result_t got;
    string         tag;
    c   = cases[idx];
    tag = $sformatf("case %0d operand %h", idx, c.operand);
    axil_write(REG_CTRL, {29'd0, c.rm}, 4'hF, resp);
    check_resp({tag, " mode write"}, resp, c.ctrl_resp);
    axil_write(REG_OPERAND, c.operand, 4'hF, resp);
    check_resp({tag, " operand write"}, resp, RESP_OKAY);
    if (c.busy_poke) begin
      // Busy without done right after start
      axil_read(REG_STATUS, 0, word, resp);
      check_status({tag, " status after start"}, word, 32'h1, 32'h3);
      axil_write(REG_OPERAND, 32'h40800000, 4'hF, resp);
      check_resp({tag, " operand write while busy"}, resp, RESP_SLVERR);
    end
    wait_done();
    axil_read(REG_RESULT, c.stall_read ? STALL_CYCLES : 0, word, resp);
    check_resp({tag, " result read"}, resp, RESP_OKAY);
    axil_read(REG_STATUS, 0, status, resp);
    check_status({tag, " status at end"}, status, 32'h2, 32'h3);
    // Flags come from status bits 2 and 3
    got.value   = word;
    got.invalid = status[2];
    got.inexact = status[3];
    check_result(tag, got, c.want);
  endtask

  task automatic check_reset_values();
    logic [31:0] word;
    axil_resp_e  resp;
    axil_read(REG_CTRL, 0, word, resp);
    check_resp("mode read after reset", resp, RESP_OKAY);
    check_data("mode after reset", word, 32'h0);
    axil_read(REG_STATUS, 0, word, resp);
    check_status("status after reset", word, 32'h0, 32'hF);
    axil_read(REG_RESULT, 0, word, resp);
    check_data("result after reset", word, 32'h0);
  endtask

  task automatic check_decode_errors();
    logic [31:0] word;
    axil_resp_e  resp;
    axil_write(REG_RESULT, 32'h12345678, 4'hF, resp);
    check_resp("write to result", resp, RESP_DECERR);
    axil_write(REG_STATUS, 32'h0000000F, 4'hF, resp);
    check_resp("write to status", resp, RESP_DECERR);
    axil_write(8'h10, 32'h0, 4'hF, resp);
    check_resp("write above the window", resp, RESP_DECERR);
    axil_read(8'h14, 0, word, resp);
    check_resp("read above the window", resp, RESP_DECERR);
    // Inside the window but not a register
    axil_read(8'h02, 0, word, resp);
    check_resp("read of unaligned offset", resp, RESP_DECERR);
    axil_read(REG_RESULT, 0, word, resp);
    check_data("result after decode errors", word, cases[cases.size() - 1].want.value);
  endtask

  task automatic check_partial_strobes();
    logic [31:0] word;
    axil_resp_e  resp;
    axil_write(REG_CTRL, 32'h1, 4'h1, resp);
    check_resp("mode write with partial strobe", resp, RESP_SLVERR);
    axil_read(REG_CTRL, 0, word, resp);
    check_data("mode after partial strobe", word, {29'd0, cases[cases.size() - 1].rm});
    axil_write(REG_OPERAND, 32'h40800000, 4'h7, resp);
    check_resp("operand write with partial strobe", resp, RESP_SLVERR);
    // No start, so done stays from the last operation
    axil_read(REG_STATUS, 0, word, resp);
    check_status("status after partial strobe", word, 32'h2, 32'h3);
  endtask

  task automatic finish_test(input string name, input int mark);
    tests++;
    if (errors == mark) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d mismatches", name, errors - mark);
    end
  endtask

  initial begin : main
    int mark;
    clk          = 1'b0;
    rst          = 1'b1;
    axil_req     = '0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    load_cases();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    mark = errors;
    check_reset_values();
    finish_test("reset values", mark);
    foreach (cases[i]) begin
      mark = errors;
      run_case(i);
      finish_test($sformatf("case %0d", i), mark);
    end
    mark = errors;
    check_decode_errors();
    finish_test("decode errors", mark);
    mark = errors;
    check_partial_strobes();
    finish_test("partial strobes", mark);
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+bench
verilog/fsqrt_pkg.sv
verilog/fsqrt_unpack.sv
verilog/fsqrt_core.sv
verilog/fsqrt_round.sv
verilog/fsqrt.sv
verilog/fsqrt_axil_regs.sv
verilog/fsqrt_top.sv
bench/fsqrt_tb.sv

/* verilog/fsqrt.sv */
`timescale 1ns/1ps

module fsqrt import fsqrt_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  logic [31:0]   operand,
  input  rm_e           rm,
  output logic          busy,
  output logic          done,
  output fsqrt_result_t result
);

  logic [31:0]   op_q;
  rm_e           rm_q;
  // Unpacked operand valid
  logic          launch_q;
  logic          accept;
  fp_unpacked_t  unpacked;
  logic          is_special;
  logic          core_start;
  logic          core_done;
  root_t         root;
  fsqrt_result_t rounded;
  fsqrt_result_t special;

  assign accept = start && !busy;

  fsqrt_unpack fsqrt_unpack_inst (
    .operand  (op_q),
    .unpacked (unpacked)
  );

  // Only normal operands need the iteration
  assign is_special = (unpacked.cls != FP_NORMAL);
  assign core_start = launch_q && !is_special;

  fsqrt_core fsqrt_core_inst (
    .clk      (clk),
    .rst      (rst),
    .start    (core_start),
    .unpacked (unpacked),
    .done     (core_done),
    .root     (root)
  );

  fsqrt_round fsqrt_round_inst (
    .root   (root),
    .rm     (rm_q),
    .result (rounded)
  );

  //////////////////////////////
  // Special operands
  //////////////////////////////

  // Default is the quiet NaN answer
  always_comb begin
    special.value   = CANON_NAN;
    special.invalid = 1'b0;
    special.inexact = 1'b0;
    case (unpacked.cls)
      FP_ZERO:         special.value = {unpacked.sign, 31'd0};
      FP_INF:          special.value = POS_INF;
      FP_SNAN, FP_NEG: special.invalid = 1'b1;
      default:         special.invalid = 1'b0;
    endcase
  end

  // Operand and mode capture
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= operand;
      rm_q <= rm;
    end
  end

  // Sequencing
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      launch_q <= 1'b0;
      result   <= '0;
    end else begin
      launch_q <= accept;
      done     <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
      end
      if (launch_q && is_special) begin
        result <= special;
        done   <= 1'b1;
        busy   <= 1'b0;
      end else if (core_done) begin
        result <= rounded;
        done   <= 1'b1;
        busy   <= 1'b0;
      end
    end
  end

endmodule

/* verilog/fsqrt_axil_regs.sv */
`timescale 1ns/1ps

module fsqrt_axil_regs import fsqrt_pkg::*; #(
  parameter int ADDR_W = 4
) (
  input  logic          clk,
  input  logic          rst,
  input  axil_req_t     axil_req,
  output axil_rsp_t     axil_rsp,
  input  logic          busy,
  input  logic          done,
  input  fsqrt_result_t result,
  output logic          start,
  output logic [31:0]   operand,
  output rm_e           rm
);

  // Write channel
  logic        aw_held;
  logic [7:0]  aw_addr_q;
  logic        w_held;
  logic [31:0] w_data_q;
  logic [3:0]  w_strb_q;
  logic        bvalid_q;
  axil_resp_e  bresp_q;
  logic        awready;
  logic        wready;
  logic        wr_go;
  axil_resp_e  wr_resp;
  // Read channel
  logic        rvalid_q;
  logic [31:0] rdata_q;
  axil_resp_e  rresp_q;
  logic        arready;
  logic [31:0] rd_data;
  axil_resp_e  rd_resp;
  // Unit state
  logic          done_q;
  fsqrt_result_t result_q;
  logic [31:0]   status;

  // Offset lies inside the decoded window
  function automatic logic in_span(logic [7:0] addr);
    return (addr >> ADDR_W) == 8'd0;
  endfunction

  assign awready = !aw_held && !bvalid_q;
  assign wready  = !w_held && !bvalid_q;
  assign arready = !rvalid_q;
  assign wr_go   = aw_held && w_held;
  assign status  = {28'd0, result_q.inexact, result_q.invalid, done_q, busy};

  //////////////////////////////
  // Write decode
  //////////////////////////////

  always_comb begin
    wr_resp = RESP_DECERR;
    if (in_span(aw_addr_q)) begin
      case (aw_addr_q)
        REG_OPERAND: begin
          if (w_strb_q != 4'hF || busy) wr_resp = RESP_SLVERR;
          else wr_resp = RESP_OKAY;
        end
        REG_CTRL: begin
          // Legal modes stop at RMM
          if (w_strb_q != 4'hF || w_data_q[2:0] > 3'd4) wr_resp = RESP_SLVERR;
          else wr_resp = RESP_OKAY;
        end
        // Status and result are read-only
        default: wr_resp = RESP_DECERR;
      endcase
    end
  end

  // Read decode
  always_comb begin
    rd_data = '0;
    rd_resp = RESP_DECERR;
    if (in_span(axil_req.araddr)) begin
      rd_resp = RESP_OKAY;
      case (axil_req.araddr)
        REG_OPERAND: rd_data = operand;
        REG_CTRL:    rd_data = {29'd0, rm};
        REG_STATUS:  rd_data = status;
        REG_RESULT:  rd_data = result_q.value;
        default:     rd_resp = RESP_DECERR;
      endcase
    end
  end

  //////////////////////////////
  // Channel state
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (axil_req.awvalid && awready) aw_held <= 1'b1;
      if (axil_req.wvalid && wready) w_held <= 1'b1;
      if (bvalid_q && axil_req.bready) bvalid_q <= 1'b0;
      // Both halves in, answer next cycle
      if (wr_go) begin
        aw_held  <= 1'b0;
        w_held   <= 1'b0;
        bvalid_q <= 1'b1;
      end
      if (axil_req.arvalid && arready) rvalid_q <= 1'b1;
      else if (rvalid_q && axil_req.rready) rvalid_q <= 1'b0;
    end
  end

  // Held address, data and responses
  always_ff @(posedge clk) begin
    if (axil_req.awvalid && awready) aw_addr_q <= axil_req.awaddr;
    if (axil_req.wvalid && wready) begin
      w_data_q <= axil_req.wdata;
      w_strb_q <= axil_req.wstrb;
    end
    if (wr_go) bresp_q <= wr_resp;
    if (axil_req.arvalid && arready) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  // Registers toward the unit
  always_ff @(posedge clk) begin
    if (rst) begin
      operand  <= '0;
      rm       <= RM_RNE;
      start    <= 1'b0;
      done_q   <= 1'b0;
      result_q <= '0;
    end else begin
      start <= 1'b0;
      if (wr_go && wr_resp == RESP_OKAY) begin
        if (aw_addr_q == REG_OPERAND) begin
          operand <= w_data_q;
          start   <= 1'b1;
          done_q  <= 1'b0;
        end
        if (aw_addr_q == REG_CTRL) rm <= rm_e'(w_data_q[2:0]);
      end
      if (done) begin
        done_q   <= 1'b1;
        result_q <= result;
      end
    end
  end

  assign axil_rsp.awready = awready;
  assign axil_rsp.wready  = wready;
  assign axil_rsp.bresp   = bresp_q;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.arready = arready;
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = rresp_q;
  assign axil_rsp.rvalid  = rvalid_q;

endmodule

/* verilog/fsqrt_core.sv */
`timescale 1ns/1ps

module fsqrt_core import fsqrt_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  fp_unpacked_t unpacked,
  output logic         done,
  output root_t        root
);

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_ITERATE,
    CORE_FINISH
  } core_state_e;

  core_state_e state;
  logic [4:0]  cnt;
  // Radicand, two bits consumed per step
  logic [51:0] rad_q;
  logic [26:0] rem_q;
  // Partial root
  logic [25:0] q_q;
  logic [9:0]  exp_q;
  logic [28:0] cand;
  logic [28:0] trial;
  logic [28:0] diff;
  logic        fits;

  //////////////////////////////
  // Restoring step
  //////////////////////////////

  // Bring down next pair, try 4q+1
  assign cand  = {rem_q, rad_q[51:50]};
  assign trial = {1'b0, q_q, 2'b01};
  assign diff  = cand - trial;
  assign fits  = (cand >= trial);

  // FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= CORE_IDLE;
      cnt   <= 5'd0;
    end else begin
      case (state)
        CORE_IDLE: begin
          if (start) begin
            state <= CORE_ITERATE;
            cnt   <= 5'd0;
          end
        end
        CORE_ITERATE: begin
          cnt <= cnt + 5'd1;
          if (cnt == 5'(ROOT_BITS - 1)) begin
            state <= CORE_FINISH;
          end
        end
        CORE_FINISH: state <= CORE_IDLE;
        default:     state <= CORE_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state == CORE_IDLE && start) begin
      // 2.23 radicand scaled so the root comes out as 1.25
      rad_q <= {unpacked.mant, 27'd0};
      rem_q <= '0;
      q_q   <= '0;
      // Exponent is even, arithmetic halve
      exp_q <= {unpacked.exp[8], unpacked.exp[8], unpacked.exp[8:1]};
    end else if (state == CORE_ITERATE) begin
      rad_q <= {rad_q[49:0], 2'b00};
      if (fits) begin
        rem_q <= diff[26:0];
        q_q   <= {q_q[24:0], 1'b1};
      end else begin
        rem_q <= cand[26:0];
        q_q   <= {q_q[24:0], 1'b0};
      end
    end
  end

  assign done        = (state == CORE_FINISH);
  assign root.exp    = exp_q;
  assign root.root   = q_q;
  // Anything left over is below the round bit
  assign root.sticky = |rem_q;

endmodule

/* verilog/fsqrt_pkg.sv */
package fsqrt_pkg;

  //////////////////////////////
  // Operand and rounding types
  //////////////////////////////

  // Rounding mode, codes 5 to 7 illegal
  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } rm_e;

  // Operand class, neg is any negative nonzero
  typedef enum logic [2:0] {
    FP_ZERO,
    FP_NORMAL,
    FP_INF,
    FP_QNAN,
    FP_SNAN,
    FP_NEG
  } fp_class_e;

  // Unpacked operand
  // mant is the 24-bit significand with hidden bit, shifted up once for odd exponents
  typedef struct packed {
    logic              sign;
    fp_class_e         cls;
    logic signed [8:0] exp;
    logic [24:0]       mant;
  } fp_unpacked_t;

  // Core result, 24 mantissa bits plus guard and round
  typedef struct packed {
    logic signed [9:0] exp;
    logic [25:0]       root;
    logic              sticky;
  } root_t;

  typedef struct packed {
    logic [31:0] value;
    logic        invalid;
    logic        inexact;
  } fsqrt_result_t;

  //////////////////////////////
  // AXI4-Lite
  //////////////////////////////

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axil_resp_e;

  // Manager side
  typedef struct packed {
    logic [7:0]  awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  // Slave side
  typedef struct packed {
    logic        awready;
    logic        wready;
    axil_resp_e  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    axil_resp_e  rresp;
    logic        rvalid;
  } axil_rsp_t;

  // Register map
  localparam logic [7:0] REG_OPERAND = 8'h00;
  localparam logic [7:0] REG_CTRL    = 8'h04;
  localparam logic [7:0] REG_STATUS  = 8'h08;
  localparam logic [7:0] REG_RESULT  = 8'h0C;

  // Number format
  localparam logic [31:0] CANON_NAN = 32'h7FC0_0000;
  localparam logic [31:0] POS_INF   = 32'h7F80_0000;
  localparam logic [9:0]  EXP_BIAS  = 10'd127;
  localparam int          ROOT_BITS = 26;

endpackage

/* verilog/fsqrt_round.sv */
`timescale 1ns/1ps

module fsqrt_round import fsqrt_pkg::*; (
  input  root_t         root,
  input  rm_e           rm,
  output fsqrt_result_t result
);

  logic [23:0] mant;
  logic        guard;
  logic        round_bit;
  logic        sticky;
  logic        lsb;
  logic        inexact;
  logic        inc;
  logic [24:0] mant_rnd;
  logic        carry;
  logic [22:0] frac;
  logic [9:0]  exp_b;

  // Root layout 1.23 then guard, round
  assign mant      = root.root[25:2];
  assign guard     = root.root[1];
  assign round_bit = root.root[0];
  assign sticky    = root.sticky;
  assign lsb       = mant[0];
  assign inexact   = guard | round_bit | sticky;

  //////////////////////////////
  // Increment decision
  //////////////////////////////

  // Root is never negative
  always_comb begin
    case (rm)
      // Ties go to even
      RM_RNE:  inc = guard & (round_bit | sticky | lsb);
      RM_RUP:  inc = inexact;
      // Ties away from zero
      RM_RMM:  inc = guard;
      // Truncate for RTZ and RDN
      default: inc = 1'b0;
    endcase
  end

  assign mant_rnd = {1'b0, mant} + {24'd0, inc};

  // Overflow to 2.0 leaves an all-zero fraction
  assign carry = mant_rnd[24];
  assign frac  = carry ? mant_rnd[23:1] : mant_rnd[22:0];

  // Biased exponent, always in normal range for a root
  assign exp_b = root.exp + EXP_BIAS + {9'd0, carry};

  // Pack
  assign result.value   = {1'b0, exp_b[7:0], frac};
  assign result.invalid = 1'b0;
  assign result.inexact = inexact;

endmodule

/* verilog/fsqrt_top.sv */
`timescale 1ns/1ps

module fsqrt_top import fsqrt_pkg::*; #(
  parameter int ADDR_W = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp
);

  // Register slave to unit
  logic          start;
  logic [31:0]   operand;
  rm_e           rm;
  // Unit to register slave
  logic          busy;
  logic          done;
  fsqrt_result_t result;

  fsqrt_axil_regs #(
    .ADDR_W (ADDR_W)
  ) fsqrt_axil_regs_inst (
    .clk      (clk),
    .rst      (rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .busy     (busy),
    .done     (done),
    .result   (result),
    .start    (start),
    .operand  (operand),
    .rm       (rm)
  );

  fsqrt fsqrt_inst (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .operand (operand),
    .rm      (rm),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

endmodule

/* verilog/fsqrt_unpack.sv */
`timescale 1ns/1ps

module fsqrt_unpack import fsqrt_pkg::*; (
  input  logic [31:0]  operand,
  output fp_unpacked_t unpacked
);

  logic        sign;
  logic [7:0]  exp_fld;
  logic [22:0] frac;
  logic        exp_zero;
  logic        exp_ones;
  logic [4:0]  lzc;
  logic [23:0] mant;
  logic [9:0]  exp_raw;
  logic        odd;
  logic [9:0]  exp_even;
  fp_class_e   cls;

  // Field split
  assign sign     = operand[31];
  assign exp_fld  = operand[30:23];
  assign frac     = operand[22:0];
  assign exp_zero = (exp_fld == 8'h00);
  assign exp_ones = (exp_fld == 8'hFF);

  // Leading zeros of a subnormal significand
  // Highest set bit is the last one to write
  always_comb begin
    lzc = 5'd0;
    for (int i = 0; i < 23; i++) begin
      if (frac[i]) begin
        lzc = 5'(23 - i);
      end
    end
  end

  // Normalize, hidden bit lands on bit 23
  always_comb begin
    if (exp_zero) begin
      mant    = {1'b0, frac} << lzc;
      exp_raw = 10'd1 - EXP_BIAS - {5'd0, lzc};
    end else begin
      mant    = {1'b1, frac};
      exp_raw = {2'b00, exp_fld} - EXP_BIAS;
    end
  end

  // Odd exponent borrows one into the radicand
  assign odd      = exp_raw[0];
  assign exp_even = exp_raw - {9'd0, odd};

  // NaN first, sign of a NaN is ignored
  always_comb begin
    if (exp_ones && frac != 23'd0) begin
      cls = frac[22] ? FP_QNAN : FP_SNAN;
    end else if (exp_zero && frac == 23'd0) begin
      cls = FP_ZERO;
    end else if (sign) begin
      cls = FP_NEG;
    end else if (exp_ones) begin
      cls = FP_INF;
    end else begin
      cls = FP_NORMAL;
    end
  end

  assign unpacked.sign = sign;
  assign unpacked.cls  = cls;
  assign unpacked.exp  = exp_even[8:0];
  assign unpacked.mant = odd ? {mant, 1'b0} : {1'b0, mant};

endmodule
